// ==== src/mem_stage_pkg.sv ====
// ====================
// memory stage package
// widths, memory sizing and the records passed between stages
// ====================
package mem_stage_pkg;

    localparam int XLEN            = 32;
    localparam int STRB_BITS       = XLEN / 8;
    localparam int RAM_DEPTH_WORDS = 256;
    localparam int RAM_ADDR_BITS   = 8;
    localparam int RAM_LATENCY     = 2;
    localparam int RAM_CNT_BITS    = $clog2(RAM_LATENCY + 1);

    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [4:0]               reg_idx_t;
    typedef logic [1:0]               csr_idx_t;
    typedef logic [STRB_BITS-1:0]     strb_t;
    typedef logic [RAM_ADDR_BITS-1:0] ram_addr_t;
    typedef logic [RAM_CNT_BITS-1:0]  ram_cnt_t;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_e;

    // access controller FSM
    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_release,
        st_done
    } acc_state_e;

    // ==================== stage records
    typedef struct packed {
        xlen_t     pc;
        xlen_t     inst;
        xlen_t     alu_out;
        xlen_t     csr_out;
        xlen_t     store_data;
        reg_idx_t  rd;
        csr_idx_t  csr_rd;
        logic      write_gpr;
        logic      write_csr;
        logic      mem_read;
        logic      mem_write;
        mem_size_e size;
        logic      is_unsigned;
    } mem_op_t;

    typedef struct packed {
        xlen_t    pc;
        xlen_t    inst;
        xlen_t    alu_out;
        xlen_t    csr_out;
        xlen_t    rdata;
        reg_idx_t rd;
        csr_idx_t csr_rd;
        logic     write_gpr;
        logic     write_csr;
        // writeback picks rdata over alu_out
        logic     mem_read;
    } mem_res_t;

    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        csr_idx_t csr_rs;
    } src_regs_t;

    typedef struct packed {
        reg_idx_t rd;
        csr_idx_t csr_rd;
        logic     write_gpr;
        logic     write_csr;
        xlen_t    gpr_data;
        xlen_t    csr_data;
    } wb_fwd_t;

    typedef struct packed {
        xlen_t rs1_data;
        xlen_t rs2_data;
        xlen_t csr_data;
        logic  rs1_hit;
        logic  rs2_hit;
        logic  csr_hit;
    } fwd_t;

endpackage

// ==== src/mem_lane_align.sv ====
// ====================
// byte lane alignment
// store lane placement with strobes, load extraction with extension
// ====================
`timescale 1ns/1ps

module mem_lane_align
    import mem_stage_pkg::*;
(
    input  mem_size_e  size,
    input  logic       is_unsigned,
    input  logic [1:0] byte_off,
    input  xlen_t      store_data,
    input  xlen_t      ram_rdata,
    output xlen_t      lane_wdata,
    output strb_t      wstrb,
    output xlen_t      load_data
);

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    // store side: replicate into all lanes, strobe picks the target
    always_comb begin
        case (size)
            size_byte: begin
                lane_wdata = {4{store_data[7:0]}};
                wstrb      = strb_t'(4'b0001 << byte_off);
            end
            size_half: begin
                lane_wdata = {2{store_data[15:0]}};
                wstrb      = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                lane_wdata = store_data;
                wstrb      = 4'b1111;
            end
        endcase
    end

    // load side
    always_comb begin
        case (byte_off)
            2'd0:    ld_byte = ram_rdata[7:0];
            2'd1:    ld_byte = ram_rdata[15:8];
            2'd2:    ld_byte = ram_rdata[23:16];
            default: ld_byte = ram_rdata[31:24];
        endcase
        ld_half = byte_off[1] ? ram_rdata[31:16] : ram_rdata[15:0];
    end

    always_comb begin
        case (size)
            size_byte: begin
                if (is_unsigned) begin
                    load_data = {24'd0, ld_byte};
                end else begin
                    load_data = {{24{ld_byte[7]}}, ld_byte};
                end
            end
            size_half: begin
                if (is_unsigned) begin
                    load_data = {16'd0, ld_half};
                end else begin
                    load_data = {{16{ld_half[15]}}, ld_half};
                end
            end
            default: load_data = ram_rdata;
        endcase
    end

endmodule

// ==== src/mem_access_ctrl.sv ====
// ====================
// memory access controller
// four-phase requester, one load or store per start
// ====================
`timescale 1ns/1ps

module mem_access_ctrl
    import mem_stage_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      is_write,
    input  xlen_t     addr,
    input  xlen_t     wdata,
    input  strb_t     wstrb,
    output logic      req,
    output ram_addr_t word_addr,
    output xlen_t     ram_wdata,
    output strb_t     ram_wstrb,
    output logic      we,
    input  logic      ack,
    input  xlen_t     ram_rdata,
    output logic      busy,
    output logic      done,
    output xlen_t     rdata_q
);

    acc_state_e state;
    acc_state_e state_nxt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_nxt = st_req;
                end
            end
            // hold req until the responder acks
            st_req: begin
                if (ack) begin
                    state_nxt = st_release;
                end
            end
            st_release: begin
                if (!ack) begin
                    state_nxt = st_done;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    // request latched at start, read data latched on ack
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            word_addr <= addr[RAM_ADDR_BITS+1:2];
            ram_wdata <= wdata;
            ram_wstrb <= wstrb;
            we        <= is_write;
        end
        if (state == st_req && ack) begin
            rdata_q <= ram_rdata;
        end
    end

    assign req  = (state == st_req);
    assign busy = (state == st_req) || (state == st_release);
    assign done = (state == st_done);

endmodule

// ==== src/mem_data_ram.sv ====
// ====================
// data memory model
// word array with byte strobes behind a four-phase responder
// ====================
`timescale 1ns/1ps

module mem_data_ram
    import mem_stage_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req,
    input  ram_addr_t word_addr,
    input  xlen_t     wdata,
    input  strb_t     wstrb,
    input  logic      we,
    output logic      ack,
    output xlen_t     rdata
);

    xlen_t    mem [RAM_DEPTH_WORDS];
    ram_cnt_t cnt;
    logic     ack_rise;

    // last delay cycle with req still up
    assign ack_rise = req && !ack && (cnt == ram_cnt_t'(RAM_LATENCY - 1));

    // ==================== handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
            cnt <= '0;
        end else begin
            if (ack_rise) begin
                ack <= 1'b1;
                cnt <= '0;
            end else if (req && !ack) begin
                cnt <= cnt + 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0;
            end
        end
    end

    // ==================== array
    // access happens on the edge that raises ack
    always_ff @(posedge clk) begin
        if (ack_rise) begin
            rdata <= mem[word_addr];
            if (we) begin
                for (int i = 0; i < STRB_BITS; i++) begin
                    if (wstrb[i]) begin
                        mem[word_addr][i*8 +: 8] <= wdata[i*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

// ==== src/mem_hazard_unit.sv ====
// ====================
// hazard and forwarding unit
// operand bypass for execute and decode, pipeline stalls
// ====================
`timescale 1ns/1ps

module mem_hazard_unit
    import mem_stage_pkg::*;
(
    input  reg_idx_t  op_rd,
    input  csr_idx_t  op_csr_rd,
    input  logic      op_write_gpr,
    input  logic      op_write_csr,
    input  logic      op_is_load,
    input  xlen_t     op_result,
    input  xlen_t     op_csr_out,
    input  logic      load_done,
    input  xlen_t     load_data,
    input  logic      busy,
    input  src_regs_t id_srcs,
    input  src_regs_t ex_srcs,
    input  wb_fwd_t   wb,
    output fwd_t      fwd_ex,
    output fwd_t      fwd_id,
    output logic      stall_if,
    output logic      stall_id,
    output logic      stall_ex,
    output logic      stall_me
);

    typedef struct packed {
        logic  hit;
        xlen_t data;
    } sel_t;

    sel_t ex_rs1;
    sel_t ex_rs2;
    sel_t ex_csr;
    sel_t id_rs1;
    sel_t id_rs2;
    sel_t id_csr;
    logic load_use;

    function automatic sel_t wb_gpr(input reg_idx_t src);
        sel_t s;
        s = '{hit: 1'b0, data: '0};
        if (src != '0 && wb.write_gpr && wb.rd == src) begin
            s = '{hit: 1'b1, data: wb.gpr_data};
        end
        return s;
    endfunction

    function automatic sel_t wb_csr(input csr_idx_t src);
        sel_t s;
        s = '{hit: 1'b0, data: '0};
        if (wb.write_csr && wb.csr_rd == src) begin
            s = '{hit: 1'b1, data: wb.csr_data};
        end
        return s;
    endfunction

    // mem stage wins, a pending load gives nothing until done
    function automatic sel_t ex_gpr(input reg_idx_t src);
        sel_t s;
        s = wb_gpr(src);
        if (src != '0 && op_write_gpr && op_rd == src) begin
            if (!op_is_load) begin
                s = '{hit: 1'b1, data: op_result};
            end else if (load_done) begin
                s = '{hit: 1'b1, data: load_data};
            end else begin
                s = '{hit: 1'b0, data: '0};
            end
        end
        return s;
    endfunction

    always_comb begin
        ex_rs1 = ex_gpr(ex_srcs.rs1);
        ex_rs2 = ex_gpr(ex_srcs.rs2);
        ex_csr = wb_csr(ex_srcs.csr_rs);
        if (op_write_csr && op_csr_rd == ex_srcs.csr_rs) begin
            ex_csr = '{hit: 1'b1, data: op_csr_out};
        end
        id_rs1 = wb_gpr(id_srcs.rs1);
        id_rs2 = wb_gpr(id_srcs.rs2);
        id_csr = wb_csr(id_srcs.csr_rs);
    end

    assign fwd_ex = '{rs1_data: ex_rs1.data, rs2_data: ex_rs2.data, csr_data: ex_csr.data,
                      rs1_hit: ex_rs1.hit, rs2_hit: ex_rs2.hit, csr_hit: ex_csr.hit};
    assign fwd_id = '{rs1_data: id_rs1.data, rs2_data: id_rs2.data, csr_data: id_csr.data,
                      rs1_hit: id_rs1.hit, rs2_hit: id_rs2.hit, csr_hit: id_csr.hit};

    // ==================== stalls
    assign load_use = op_is_load && !load_done && op_rd != '0
                      && (op_rd == ex_srcs.rs1 || op_rd == ex_srcs.rs2);

    assign stall_if = busy || load_use;
    assign stall_id = busy || load_use;
    assign stall_ex = busy || load_use;
    assign stall_me = busy;

endmodule

// ==== src/mem_stage_top.sv ====
// ====================
// memory access stage
// lane alignment, access FSM, data RAM and hazard unit
// ====================
`timescale 1ns/1ps

module mem_stage_top
    import mem_stage_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  mem_op_t   op,
    input  logic      op_valid,
    input  src_regs_t id_srcs,
    input  src_regs_t ex_srcs,
    input  wb_fwd_t   wb,
    output mem_res_t  res,
    output logic      res_valid,
    output fwd_t      fwd_ex,
    output fwd_t      fwd_id,
    output logic      stall_if,
    output logic      stall_id,
    output logic      stall_ex,
    output logic      stall_me
);

    logic      mem_op;
    logic      busy;
    logic      done;
    xlen_t     lane_wdata;
    strb_t     lane_wstrb;
    xlen_t     load_data;
    xlen_t     rdata_q;
    logic      req;
    logic      ack;
    logic      we;
    ram_addr_t word_addr;
    xlen_t     ram_wdata;
    strb_t     ram_wstrb;
    xlen_t     ram_rdata;

    assign mem_op = op_valid && (op.mem_read || op.mem_write);

    mem_lane_align u_align (
        .size       (op.size),
        .is_unsigned(op.is_unsigned),
        .byte_off   (op.alu_out[1:0]),
        .store_data (op.store_data),
        .ram_rdata  (rdata_q),
        .lane_wdata (lane_wdata),
        .wstrb      (lane_wstrb),
        .load_data  (load_data)
    );

    mem_access_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (mem_op),
        .is_write (op.mem_write),
        .addr     (op.alu_out),
        .wdata    (lane_wdata),
        .wstrb    (lane_wstrb),
        .req      (req),
        .word_addr(word_addr),
        .ram_wdata(ram_wdata),
        .ram_wstrb(ram_wstrb),
        .we       (we),
        .ack      (ack),
        .ram_rdata(ram_rdata),
        .busy     (busy),
        .done     (done),
        .rdata_q  (rdata_q)
    );

    mem_data_ram u_ram (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .word_addr(word_addr),
        .wdata    (ram_wdata),
        .wstrb    (ram_wstrb),
        .we       (we),
        .ack      (ack),
        .rdata    (ram_rdata)
    );

    mem_hazard_unit u_hazard (
        .op_rd       (op.rd),
        .op_csr_rd   (op.csr_rd),
        .op_write_gpr(op_valid && op.write_gpr),
        .op_write_csr(op_valid && op.write_csr),
        .op_is_load  (op_valid && op.mem_read),
        .op_result   (op.alu_out),
        .op_csr_out  (op.csr_out),
        .load_done   (done),
        .load_data   (load_data),
        .busy        (busy),
        .id_srcs     (id_srcs),
        .ex_srcs     (ex_srcs),
        .wb          (wb),
        .fwd_ex      (fwd_ex),
        .fwd_id      (fwd_id),
        .stall_if    (stall_if),
        .stall_id    (stall_id),
        .stall_ex    (stall_ex),
        .stall_me    (stall_me)
    );

    // memory ops retire on done, everything else passes straight through
    assign res_valid = mem_op ? done : op_valid;
    assign res = '{pc: op.pc, inst: op.inst, alu_out: op.alu_out, csr_out: op.csr_out,
                   rdata: load_data, rd: op.rd, csr_rd: op.csr_rd,
                   write_gpr: op.write_gpr, write_csr: op.write_csr,
                   mem_read: op.mem_read};

endmodule

// ==== verification/mem_stage_props.sv ====
// ====================
// memory stage properties
// four-phase link and stall checks, bound into the stage top
// ====================
`timescale 1ns/1ps

module mem_stage_props (
    input logic clk,
    input logic rst_n,
    input logic req,
    input logic ack,
    input logic stall_if,
    input logic stall_id,
    input logic stall_ex,
    input logic stall_me
);

    int unsigned fail_cnt = 0;

    // ==================== link
    req_hold: assert property (@(posedge clk) disable iff (!rst_n) req && !ack |=> req)
        else begin
            fail_cnt++;
            $error("req dropped before ack");
        end

    ack_hold: assert property (@(posedge clk) disable iff (!rst_n) req && ack |=> ack)
        else begin
            fail_cnt++;
            $error("ack dropped while req still high");
        end

    req_after_ack: assert property (@(posedge clk) disable iff (!rst_n) $rose(req) |-> !ack)
        else begin
            fail_cnt++;
            $error("new req raised while ack still high");
        end

    // ==================== stalls
    // access window runs from req rise to the cycle after ack falls
    stall_busy: assert property (@(posedge clk) disable iff (!rst_n)
        stall_me == (req || ack || $past(ack)))
        else begin
            fail_cnt++;
            $error("stall_me does not follow the busy access");
        end

    // active through reset
    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !(stall_if || stall_id || stall_ex || stall_me || req || ack))
        else begin
            fail_cnt++;
            $error("stall or handshake active around reset");
        end

endmodule

bind mem_stage_top mem_stage_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .ack     (ack),
    .stall_if(stall_if),
    .stall_id(stall_id),
    .stall_ex(stall_ex),
    .stall_me(stall_me)
);

// ==== verification/mem_stage_tb.sv ====
// ====================
// memory stage testbench
// random loads and stores against a byte model, forwarding and stall checks
// ====================
`timescale 1ns/1ps

module mem_stage_tb
    import mem_stage_pkg::*;
();

    logic      clk;
    logic      rst_n;
    mem_op_t   op;
    logic      op_valid;
    src_regs_t id_srcs;
    src_regs_t ex_srcs;
    wb_fwd_t   wb;
    mem_res_t  res;
    logic      res_valid;
    fwd_t      fwd_ex;
    fwd_t      fwd_id;
    logic      stall_if;
    logic      stall_id;
    logic      stall_ex;
    logic      stall_me;

    logic [7:0] model [RAM_DEPTH_WORDS*4];
    xlen_t      lfsr;
    int         errors;
    logic       abort;

    mem_stage_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic xlen_t rand_bits(input int n);
        xlen_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_eq(input string name, input xlen_t exp, input xlen_t got);
        assert (got === exp) else begin
            errors++;
            $display("ERR %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_fwd(input string name, input fwd_t exp, input fwd_t got);
        check_eq({name, ".rs1_data"}, exp.rs1_data, got.rs1_data);
        check_eq({name, ".rs2_data"}, exp.rs2_data, got.rs2_data);
        check_eq({name, ".csr_data"}, exp.csr_data, got.csr_data);
        check_eq({name, ".hits"}, {29'd0, exp.rs1_hit, exp.rs2_hit, exp.csr_hit},
                 {29'd0, got.rs1_hit, got.rs2_hit, got.csr_hit});
    endtask

    function automatic xlen_t expect_load(input mem_size_e size, input logic uns,
                                          input logic [9:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = model[a];
        h = {model[{a[9:1], 1'b1}], model[{a[9:1], 1'b0}]};
        case (size)
            size_byte: return uns ? {24'd0, b} : {{24{b[7]}}, b};
            size_half: return uns ? {16'd0, h} : {{16{h[15]}}, h};
            default: return {model[{a[9:2], 2'd3}], model[{a[9:2], 2'd2}],
                             model[{a[9:2], 2'd1}], model[{a[9:2], 2'd0}]};
        endcase
    endfunction

    task automatic write_model(input mem_size_e size, input logic [9:0] a, input xlen_t d);
        case (size)
            size_byte: model[a] = d[7:0];
            size_half: begin
                model[{a[9:1], 1'b0}] = d[7:0];
                model[{a[9:1], 1'b1}] = d[15:8];
            end
            default: begin
                for (int k = 0; k < 4; k++) begin
                    model[{a[9:2], 2'(k)}] = d[k*8 +: 8];
                end
            end
        endcase
    endtask

    function automatic mem_op_t build_op(input logic wr, input mem_size_e size,
                                         input logic uns, input logic [9:0] a,
                                         input xlen_t d, input reg_idx_t rd);
        mem_op_t o;
        o = '0;
        o.alu_out     = {22'd0, a};
        o.store_data  = d;
        o.rd          = rd;
        o.write_gpr   = !wr;
        o.mem_read    = !wr;
        o.mem_write   = wr;
        o.size        = size;
        o.is_unsigned = uns;
        return o;
    endfunction

    // one access with optional load-use checks on rs1
    task automatic run_access(input mem_op_t o, input logic lu, input xlen_t exp);
        int n;
        if (abort) begin
            return;
        end
        @(posedge clk);
        op       <= o;
        op_valid <= 1'b1;
        ex_srcs  <= lu ? src_regs_t'{rs1: o.rd, rs2: 5'd0, csr_rs: 2'd0} : src_regs_t'('0);
        // competing wb write of the same rd
        wb <= lu ? wb_fwd_t'{rd: o.rd, csr_rd: 2'd0, write_gpr: 1'b1, write_csr: 1'b0,
                             gpr_data: ~exp, csr_data: '0} : wb_fwd_t'('0);
        for (n = 0; n < 40; n++) begin
            @(negedge clk);
            if (res_valid) begin
                break;
            end
            if (n > 0) begin
                check_eq("stall_if/id/ex/me", 32'hf,
                         {28'd0, stall_if, stall_id, stall_ex, stall_me});
            end
            if (lu) begin
                check_eq("stall_ex", 32'h1, {31'd0, stall_ex});
                check_eq("fwd_ex.rs1_hit", 32'h0, {31'd0, fwd_ex.rs1_hit});
            end
        end
        if (!res_valid) begin
            errors++;
            abort = 1'b1;
            $display("timeout: access to address %h never completed", o.alu_out);
        end else if (o.mem_read) begin
            check_eq("res.rdata", exp, res.rdata);
            check_eq("res.rd", {27'd0, o.rd}, {27'd0, res.rd});
            check_eq("res.mem_read", 32'h1, {31'd0, res.mem_read});
            if (lu) begin
                check_eq("fwd_ex.rs1_hit", 32'h1, {31'd0, fwd_ex.rs1_hit});
                check_eq("fwd_ex.rs1_data", exp, fwd_ex.rs1_data);
            end
        end
    endtask

    task automatic store_op(input mem_size_e size, input logic [9:0] a, input xlen_t d);
        run_access(build_op(1'b1, size, 1'b0, a, d, 5'd0), 1'b0, '0);
        write_model(size, a, d);
    endtask

    task automatic load_op(input mem_size_e size, input logic uns, input logic [9:0] a,
                           input logic lu);
        reg_idx_t rd;
        rd = reg_idx_t'(rand_bits(5));
        if (rd == '0) begin
            rd = 5'd1;
        end
        run_access(build_op(1'b0, size, uns, a, '0, rd), lu, expect_load(size, uns, a));
    endtask

    // plain op in MEM plus wb and source indices
    task automatic apply_fwd(input mem_op_t o, input logic v, input wb_fwd_t w,
                             input src_regs_t s);
        @(posedge clk);
        op       <= o;
        op_valid <= v;
        wb       <= w;
        ex_srcs  <= s;
        id_srcs  <= s;
        @(negedge clk);
    endtask

    initial begin
        mem_size_e  sz;
        logic [1:0] k;
        logic [9:0] a;
        reg_idx_t   rd;
        csr_idx_t   cs;
        mem_op_t    alu_op;
        wb_fwd_t    wbv;
        src_regs_t  srcs;
        lfsr     = 32'd32034;
        errors   = 0;
        abort    = 1'b0;
        rst_n    = 1'b0;
        op       = '0;
        op_valid = 1'b0;
        id_srcs  = '0;
        ex_srcs  = '0;
        wb       = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // fill every word since the RAM has no reset contents
        for (int w = 0; w < RAM_DEPTH_WORDS; w++) begin
            store_op(size_word, 10'(w * 4), rand_bits(32));
        end

        // every byte and half lane followed by the whole word
        for (int off = 0; off < 4; off++) begin
            a = 10'(rand_bits(10) & 32'h3fc) | 10'(off);
            store_op(size_byte, a, rand_bits(32));
            load_op(size_byte, 1'b0, a, 1'b0);
            load_op(size_byte, 1'b1, a, 1'b0);
            load_op(size_word, 1'b0, a & 10'h3fc, 1'b0);
            if (off % 2 == 0) begin
                store_op(size_half, a, rand_bits(32));
                load_op(size_half, 1'b0, a, 1'b0);
                load_op(size_half, 1'b1, a, 1'b0);
                load_op(size_word, 1'b0, a & 10'h3fc, 1'b0);
            end
        end

        // random mix
        for (int i = 0; i < 300; i++) begin
            k  = 2'(rand_bits(2));
            sz = k[1] ? size_word : (k[0] ? size_half : size_byte);
            a  = 10'(rand_bits(10));
            a  = a & ~((sz == size_word) ? 10'd3 : ((sz == size_half) ? 10'd1 : 10'd0));
            if (rand_bits(1) != 0) begin
                store_op(sz, a, rand_bits(32));
            end else begin
                load_op(sz, rand_bits(1) != 0, a, 1'b0);
            end
        end

        // load-use on rs1
        for (int i = 0; i < 6; i++) begin
            load_op(size_word, 1'b0, 10'(rand_bits(10) & 32'h3fc), 1'b1);
        end

        // ==================== forwarding
        rd = reg_idx_t'(rand_bits(5));
        if (rd == '0) begin
            rd = 5'd7;
        end
        cs = csr_idx_t'(rand_bits(2));
        alu_op           = '0;
        alu_op.pc        = rand_bits(32);
        alu_op.inst      = rand_bits(32);
        alu_op.alu_out   = rand_bits(32);
        alu_op.csr_out   = rand_bits(32);
        alu_op.rd        = rd;
        alu_op.csr_rd    = cs;
        alu_op.write_gpr = 1'b1;
        alu_op.write_csr = 1'b1;
        wbv  = '{rd: rd, csr_rd: cs, write_gpr: 1'b1, write_csr: 1'b1,
                 gpr_data: rand_bits(32), csr_data: rand_bits(32)};
        srcs = '{rs1: rd, rs2: (rd == 5'd31) ? 5'd1 : rd + 5'd1, csr_rs: cs};
        apply_fwd(alu_op, 1'b1, wbv, srcs);
        check_eq("res_valid", 32'h1, {31'd0, res_valid});
        check_eq("res.pc", alu_op.pc, res.pc);
        check_eq("res.inst", alu_op.inst, res.inst);
        check_eq("res.alu_out", alu_op.alu_out, res.alu_out);
        check_eq("res.csr_out", alu_op.csr_out, res.csr_out);
        check_eq("res.rd/csr_rd/write_gpr/write_csr/mem_read",
                 {22'd0, rd, cs, 1'b1, 1'b1, 1'b0},
                 {22'd0, res.rd, res.csr_rd, res.write_gpr, res.write_csr, res.mem_read});
        check_eq("stall_if/id/ex/me", 32'h0, {28'd0, stall_if, stall_id, stall_ex, stall_me});
        check_fwd("fwd_ex", '{alu_op.alu_out, '0, alu_op.csr_out, 1'b1, 1'b0, 1'b1}, fwd_ex);
        check_fwd("fwd_id", '{wbv.gpr_data, '0, wbv.csr_data, 1'b1, 1'b0, 1'b1}, fwd_id);
        // wb takes over once MEM is gone
        apply_fwd(alu_op, 1'b0, wbv, srcs);
        check_eq("res_valid", 32'h0, {31'd0, res_valid});
        check_fwd("fwd_ex", '{wbv.gpr_data, '0, wbv.csr_data, 1'b1, 1'b0, 1'b1}, fwd_ex);
        // x0 never forwards
        alu_op.rd = '0;
        wbv.rd    = '0;
        apply_fwd(alu_op, 1'b1, wbv, '{rs1: 5'd0, rs2: 5'd0, csr_rs: cs});
        check_fwd("fwd_ex", '{'0, '0, alu_op.csr_out, 1'b0, 1'b0, 1'b1}, fwd_ex);
        check_fwd("fwd_id", '{'0, '0, wbv.csr_data, 1'b0, 1'b0, 1'b1}, fwd_id);
        // MEM match alone reaches execute but not decode
        alu_op.rd     = rd;
        wbv.rd        = rd;
        wbv.write_gpr = 1'b0;
        wbv.write_csr = 1'b0;
        apply_fwd(alu_op, 1'b1, wbv, srcs);
        check_fwd("fwd_ex", '{alu_op.alu_out, '0, alu_op.csr_out, 1'b1, 1'b0, 1'b1}, fwd_ex);
        check_fwd("fwd_id", '{'0, '0, '0, 1'b0, 1'b0, 1'b0}, fwd_id);

        @(posedge clk);
        op_valid <= 1'b0;
        repeat (2) @(posedge clk);
        $display("errors: %0d testbench checks, %0d assertions",
                 errors, UUT.u_props.fail_cnt);
        if (errors == 0 && UUT.u_props.fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== mem_stage_top.f ====
src/mem_stage_pkg.sv
src/mem_lane_align.sv
src/mem_access_ctrl.sv
src/mem_data_ram.sv
src/mem_hazard_unit.sv
src/mem_stage_top.sv
verification/mem_stage_props.sv
verification/mem_stage_tb.sv

// ==== Makefile ====
# Verilator build and run of the memory stage testbench

BIN := obj_dir/Vmem_stage_tb

.PHONY: all run clean

all: run

$(BIN): mem_stage_top.f $(wildcard src/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module mem_stage_tb -f mem_stage_top.f

# the log decides pass or fail
run: $(BIN)
	./$(BIN) | tee sim.log
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
